// ==== mem_ss.f ====
mem_ss_param_pkg.sv
mem_fifo.sv
rr_arbiter.sv
mc.sv
cl_sram.sv
mem_ss_top.sv
mem_ss_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the mem_ss testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=mem_ss_sim

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module mem_ss_tb -f mem_ss.f -o "$BIN"; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
   exit 0
fi

echo "pass line not found in $LOG"
exit 1

// ==== mem_ss_tb.sv ====
// memory subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module mem_ss_tb
   import mem_ss_param_pkg::*;
();

   localparam int FIFO_DEPTH    = 4;
   localparam int ACCESS_CYCLES = 2;
   localparam int TIMEOUT       = 200;   // cycles allowed for any single wait

   logic       clk;
   logic       arst_n;
   t_fm_req    i_cache_req;
   t_fm_req    d_cache_req;
   logic       i_cache_ready;
   logic       d_cache_ready;
   t_fm_rd_rsp i_cache_rsp;
   t_fm_rd_rsp d_cache_rsp;

   t_fm_rd_rsp        exp_i_q[$];   // reads in flight on the I port, oldest first
   t_fm_rd_rsp        exp_d_q[$];
   logic [CL_W-1:0]   ref_mem [logic [ADDR_W-5:0]];   // keyed by line address
   bit                rsp_log[$];   // port of every response, 0 is I
   int                last_rd_cyc[2];
   int                last_rsp_cyc[2];
   int                cyc;
   int                err_cnt;
   int                stall_cnt;
   int                tests_run;
   int                tests_failed;
   int                test_err_start;
   integer            seed;
   string             cur_test;

   mem_ss_top #(
      .FIFO_DEPTH    (FIFO_DEPTH),
      .ACCESS_CYCLES (ACCESS_CYCLES)
   ) dut (
      .clk             (clk),
      .i_arst_n        (arst_n),
      .i_i_cache_req   (i_cache_req),
      .o_i_cache_ready (i_cache_ready),
      .o_i_cache_rsp   (i_cache_rsp),
      .i_d_cache_req   (d_cache_req),
      .o_d_cache_ready (d_cache_ready),
      .o_d_cache_rsp   (d_cache_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic report_mismatch(input string what, input logic [CL_W-1:0] exp_v,
                                  input logic [CL_W-1:0] act_v);
      $display("Fail %s %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
      err_cnt++;
   endtask

   // compares one response with the oldest read of its port
   task automatic check_rsp(input int port, input t_fm_rd_rsp rsp);
      t_fm_rd_rsp exp;
      int         n;
      if (rsp.valid) begin
         n = (port == 0) ? exp_i_q.size() : exp_d_q.size();
         assert (n > 0) else begin
            $display("%s: response on port %0d with no read outstanding", cur_test, port);
            err_cnt++;
         end
         if (n > 0) begin
            if (port == 0)
               exp = exp_i_q.pop_front();
            else
               exp = exp_d_q.pop_front();
            assert (rsp.tq_id == exp.tq_id) else report_mismatch("tq_id", exp.tq_id, rsp.tq_id);
            assert (rsp.data == exp.data) else report_mismatch("data", exp.data, rsp.data);
         end
         rsp_log.push_back(port[0]);
         last_rsp_cyc[port] = cyc;
      end
   endtask

   // an accepted request updates the model or queues the expected read data
   task automatic track_req(input int port, input t_fm_req req);
      t_fm_rd_rsp        exp;
      logic [ADDR_W-5:0] line;
      if (req.valid) begin
         line = req.address[ADDR_W-1:4];
         if (req.opcode == OP_WR) begin
            ref_mem[line] = req.data;
         end else begin
            exp.valid = 1'b1;
            exp.tq_id = req.tq_id;
            exp.data  = ref_mem.exists(line) ? ref_mem[line] : '0;   // memory starts cleared
            if (port == 0)
               exp_i_q.push_back(exp);
            else
               exp_d_q.push_back(exp);
            last_rd_cyc[port] = cyc;
         end
      end
   endtask

   // mid-cycle sampling keeps the monitor clear of the clock edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_rsp(0, i_cache_rsp);
         check_rsp(1, d_cache_rsp);
         track_req(0, i_cache_req);
         track_req(1, d_cache_req);
      end
   end

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic wait_ready(input int port);
      int t;
      t = 0;
      while (((port == 0) ? i_cache_ready : d_cache_ready) !== 1'b1 && t < TIMEOUT) begin
         stall_cnt++;
         @(posedge clk);
         #1;
         t++;
      end
      if (((port == 0) ? i_cache_ready : d_cache_ready) !== 1'b1) begin
         $display("%s: timed out waiting for ready on port %0d", cur_test, port);
         err_cnt++;
      end
   endtask

   // holds one request for a single accepting cycle
   task automatic send(input int port, input t_opcode op, input logic [ADDR_W-1:0] addr,
                       input logic [TQ_W-1:0] tq, input logic [CL_W-1:0] data);
      t_fm_req req;
      req = '{valid: 1'b1, opcode: op, address: addr, tq_id: tq, data: data};
      wait_ready(port);
      if (port == 0)
         i_cache_req = req;
      else
         d_cache_req = req;
      @(posedge clk);
      #1;
      if (port == 0)
         i_cache_req = '0;
      else
         d_cache_req = '0;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while ((exp_i_q.size() != 0 || exp_d_q.size() != 0) && t < TIMEOUT) begin
         @(posedge clk);
         t++;
      end
      #1;
      if (exp_i_q.size() != 0 || exp_d_q.size() != 0) begin
         $display("%s: timed out with %0d I and %0d D reads unanswered", cur_test,
                  exp_i_q.size(), exp_d_q.size());
         err_cnt++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test       = name;
      test_err_start = err_cnt;
      rsp_log.delete();
   endtask

   task automatic end_test();
      tests_run++;
      if (err_cnt != test_err_start)
         tests_failed++;
      $display("test %s finished with %0d errors", cur_test, err_cnt - test_err_start);
   endtask

   task automatic rand_op(input logic [ADDR_W-1:0] base, output t_opcode op,
                          output logic [ADDR_W-1:0] addr, output logic [TQ_W-1:0] tq,
                          output logic [CL_W-1:0] data);
      logic [31:0] r;
      r    = $random(seed);
      op   = r[31] ? OP_WR : OP_RD;
      addr = base + {12'h000, r[7:0]};   // 16 lines per region so reads hit earlier writes
      tq   = r[9:8];
      data = {$random(seed), $random(seed), $random(seed), $random(seed)};
   endtask

   initial begin
      t_opcode           op_i;
      t_opcode           op_d;
      logic [ADDR_W-1:0] addr_i;
      logic [ADDR_W-1:0] addr_d;
      logic [TQ_W-1:0]   tq_i;
      logic [TQ_W-1:0]   tq_d;
      logic [CL_W-1:0]   data_i;
      logic [CL_W-1:0]   data_d;
      seed        = 32'hd94b_f4c4;
      arst_n      = 1'b0;
      i_cache_req = '0;
      d_cache_req = '0;
      cyc         = 0;
      err_cnt     = 0;
      stall_cnt   = 0;
      tests_run   = 0;
      tests_failed = 0;
      cur_test    = "reset";
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;

      start_test("reset_idle");
      assert (i_cache_ready && d_cache_ready) else report_mismatch("ready", 2'b11,
                                                                   {d_cache_ready, i_cache_ready});
      idle(10);
      assert (rsp_log.size() == 0) else report_mismatch("responses", 0, rsp_log.size());
      end_test();

      // the very top byte of each region must still route to its port
      start_test("i_write_read");
      send(0, OP_WR, I_MEM_TOP, 2'd1, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
      idle(ACCESS_CYCLES + 4);
      send(0, OP_RD, I_MEM_TOP, 2'd2, '0);
      wait_drain();
      assert (last_rsp_cyc[0] - last_rd_cyc[0] == ACCESS_CYCLES + 2)
         else report_mismatch("latency", ACCESS_CYCLES + 2, last_rsp_cyc[0] - last_rd_cyc[0]);
      assert (rsp_log.size() == 1 && rsp_log[0] == 1'b0) else report_mismatch("i responses", 1,
                                                                              rsp_log.size());
      end_test();

      start_test("d_write_read");
      send(1, OP_WR, D_MEM_TOP, 2'd3, 128'hdead_beef_cafe_f00d_a5a5_5a5a_1111_2222);
      idle(ACCESS_CYCLES + 4);
      send(1, OP_RD, D_MEM_TOP, 2'd0, '0);
      wait_drain();
      assert (last_rsp_cyc[1] - last_rd_cyc[1] == ACCESS_CYCLES + 2)
         else report_mismatch("latency", ACCESS_CYCLES + 2, last_rsp_cyc[1] - last_rd_cyc[1]);
      send(1, OP_RD, D_MEM_BASE + 20'h40, 2'd1, '0);   // never written, reads back zero
      wait_drain();
      assert (rsp_log.size() == 2 && rsp_log[0] && rsp_log[1]) else report_mismatch(
         "d responses", 2, rsp_log.size());
      end_test();

      start_test("both_ports_rr");
      fork
         for (int k = 0; k < 4; k++)
            send(0, OP_RD, I_MEM_BASE + 20'h100 + 20'(k * 16), TQ_W'(k), '0);
         for (int k = 0; k < 4; k++)
            send(1, OP_RD, D_MEM_BASE + 20'h100 + 20'(k * 16), TQ_W'(k), '0);
      join
      wait_drain();
      assert (rsp_log.size() == 8) else report_mismatch("responses", 8, rsp_log.size());
      for (int k = 1; k < rsp_log.size(); k++)
         assert (rsp_log[k] != rsp_log[k-1]) else report_mismatch("port order", !rsp_log[k-1],
                                                                  rsp_log[k]);
      end_test();

      start_test("backpressure");
      stall_cnt = 0;
      for (int k = 0; k < FIFO_DEPTH + 3; k++)
         send(1, OP_RD, D_MEM_BASE + 20'(k * 16), TQ_W'(k), '0);
      assert (stall_cnt > 0) else begin
         $display("%s: ready never dropped during the burst", cur_test);
         err_cnt++;
      end
      wait_drain();
      assert (rsp_log.size() == FIFO_DEPTH + 3) else report_mismatch("responses", FIFO_DEPTH + 3,
                                                                     rsp_log.size());
      end_test();

      start_test("random_mix");
      for (int k = 0; k < 100; k++) begin
         rand_op(I_MEM_BASE, op_i, addr_i, tq_i, data_i);
         rand_op(D_MEM_BASE, op_d, addr_d, tq_d, data_d);
         fork
            send(0, op_i, addr_i, tq_i, data_i);
            send(1, op_d, addr_d, tq_d, data_d);
         join
      end
      wait_drain();
      end_test();

      idle(4);
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== mem_ss_top.sv ====
// memory subsystem top level
`timescale 1ns/10ps
`default_nettype none

module mem_ss_top
   import mem_ss_param_pkg::*;
#(
   parameter int FIFO_DEPTH    = 4,
   parameter int ACCESS_CYCLES = 2
) (
   input  wire logic   clk,
   input  wire logic   i_arst_n,

   input  var t_fm_req i_i_cache_req,
   output logic        o_i_cache_ready,
   output t_fm_rd_rsp  o_i_cache_rsp,

   input  var t_fm_req i_d_cache_req,
   output logic        o_d_cache_ready,
   output t_fm_rd_rsp  o_d_cache_rsp
);

   t_fm_req      sram_req;
   logic         sram_ready;
   t_sram_rd_rsp sram_rsp;

   mc #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_mc (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_i_cache_req   (i_i_cache_req),
      .o_i_cache_ready (o_i_cache_ready),
      .o_i_cache_rsp   (o_i_cache_rsp),
      .i_d_cache_req   (i_d_cache_req),
      .o_d_cache_ready (o_d_cache_ready),
      .o_d_cache_rsp   (o_d_cache_rsp),
      .o_sram_req      (sram_req),
      .i_sram_ready    (sram_ready),
      .i_sram_rsp      (sram_rsp)
   );

   cl_sram #(
      .ACCESS_CYCLES (ACCESS_CYCLES)
   ) u_cl_sram (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_req    (sram_req),
      .o_ready  (sram_ready),   // low while an access is in progress
      .o_rsp    (sram_rsp)
   );

endmodule

`default_nettype wire

// ==== cl_sram.sv ====
// cache-line SRAM model
`timescale 1ns/10ps
`default_nettype none

module cl_sram
   import mem_ss_param_pkg::*;
#(
   parameter int ACCESS_CYCLES = 2
) (
   input  wire logic    clk,
   input  wire logic    i_arst_n,
   input  var t_fm_req  i_req,
   output logic         o_ready,
   output t_sram_rd_rsp o_rsp
);

   localparam int NUM_LINES = 8192;
   localparam int IDX_LO    = 4;                         // byte offset inside a line
   localparam int IDX_W     = $clog2(NUM_LINES);
   localparam int CNT_W     = $clog2(ACCESS_CYCLES + 1);

   logic [CL_W-1:0]   mem [NUM_LINES];
   logic [IDX_W-1:0]  line_idx;
   logic [CNT_W-1:0]  busy_cnt;   // cycles left in the current access
   logic              accept;
   logic              rd_pend;    // a read is in flight
   logic              rsp_valid;
   logic [ADDR_W-1:0] rsp_addr;
   logic [TQ_W-1:0]   rsp_tq_id;
   logic [CL_W-1:0]   rsp_data;

   // contents start out as zero
   initial begin
      for (int i = 0; i < NUM_LINES; i++)
         mem[i] = '0;
   end

   assign line_idx = i_req.address[IDX_LO +: IDX_W];   // address bits 16 to 4
   assign o_ready  = (busy_cnt == '0);
   assign accept   = i_req.valid && o_ready;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         busy_cnt  <= '0;
         rd_pend   <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         if (accept) begin
            busy_cnt <= CNT_W'(ACCESS_CYCLES);
            rd_pend  <= (i_req.opcode == OP_RD);
         end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - CNT_W'(1);
            if (busy_cnt == CNT_W'(1)) begin
               rsp_valid <= rd_pend;   // last busy cycle hands out the read
               rd_pend   <= 1'b0;
            end
         end
      end
   end

   // the line is sampled at acceptance and held until the response
   always_ff @(posedge clk) begin
      if (accept) begin
         if (i_req.opcode == OP_WR)
            mem[line_idx] <= i_req.data;
         rsp_addr  <= i_req.address;
         rsp_tq_id <= i_req.tq_id;
         rsp_data  <= mem[line_idx];
      end
   end

   assign o_rsp = '{valid:   rsp_valid,
                    address: rsp_addr,
                    tq_id:   rsp_tq_id,
                    data:    rsp_data};

endmodule

`default_nettype wire

// ==== mc.sv ====
// memory controller
`timescale 1ns/10ps
`default_nettype none

module mc
   import mem_ss_param_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic     clk,
   input  wire logic     i_arst_n,

   input  var t_fm_req   i_i_cache_req,
   output logic          o_i_cache_ready,
   output t_fm_rd_rsp    o_i_cache_rsp,

   input  var t_fm_req   i_d_cache_req,
   output logic          o_d_cache_ready,
   output t_fm_rd_rsp    o_d_cache_rsp,

   output t_fm_req       o_sram_req,
   input  wire logic     i_sram_ready,
   input  var t_sram_rd_rsp i_sram_rsp
);

   localparam int NUM_PORTS = 2;   // bit 0 is the I port, bit 1 the D port

   t_fm_req              i_fifo_head;
   t_fm_req              d_fifo_head;
   logic                 i_fifo_full;
   logic                 d_fifo_full;
   logic                 i_fifo_empty;
   logic                 d_fifo_empty;
   logic [NUM_PORTS-1:0] valid_candidate;
   logic [NUM_PORTS-1:0] winner_dec_id;
   logic                 rsp_is_i;
   logic                 rsp_is_d;

   function automatic logic in_range(input logic [ADDR_W-1:0] addr,
                                     input logic [ADDR_W-1:0] base,
                                     input logic [ADDR_W-1:0] top);
      return (addr >= base) && (addr <= top);
   endfunction

   // a cache may send while its FIFO has room
   assign o_i_cache_ready = !i_fifo_full;
   assign o_d_cache_ready = !d_fifo_full;

   mem_fifo #(
      .DATA_WIDTH ($bits(t_fm_req)),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_mem_fifo_req (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_push      (i_i_cache_req.valid),
      .i_push_data (i_i_cache_req),
      .i_pop       (winner_dec_id[0]),
      .o_pop_data  (i_fifo_head),
      .o_full      (i_fifo_full),
      .o_empty     (i_fifo_empty)
   );

   mem_fifo #(
      .DATA_WIDTH ($bits(t_fm_req)),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) d_mem_fifo_req (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_push      (i_d_cache_req.valid),
      .i_push_data (i_d_cache_req),
      .i_pop       (winner_dec_id[1]),
      .o_pop_data  (d_fifo_head),
      .o_full      (d_fifo_full),
      .o_empty     (d_fifo_empty)
   );

   // candidates are hidden while the SRAM is busy, so a grant is always a transfer
   assign valid_candidate[0] = !i_fifo_empty && i_sram_ready;
   assign valid_candidate[1] = !d_fifo_empty && i_sram_ready;

   rr_arbiter #(
      .NUM_CLIENTS (NUM_PORTS)
   ) rr_arb (
      .clk               (clk),
      .i_arst_n          (i_arst_n),
      .i_valid_candidate (valid_candidate),
      .o_winner_dec_id   (winner_dec_id)   // also pops the winning FIFO
   );

   assign o_sram_req = winner_dec_id[0] ? i_fifo_head :
                       winner_dec_id[1] ? d_fifo_head :
                                          '0;

   // the owner of a read response is found from its address
   assign rsp_is_i = in_range(i_sram_rsp.address, I_MEM_BASE, I_MEM_TOP);
   assign rsp_is_d = in_range(i_sram_rsp.address, D_MEM_BASE, D_MEM_TOP);

   // a response outside both regions goes nowhere
   assign o_i_cache_rsp = '{valid: i_sram_rsp.valid && rsp_is_i,
                            tq_id: i_sram_rsp.tq_id,
                            data:  i_sram_rsp.data};
   assign o_d_cache_rsp = '{valid: i_sram_rsp.valid && rsp_is_d,
                            tq_id: i_sram_rsp.tq_id,
                            data:  i_sram_rsp.data};

endmodule

`default_nettype wire

// ==== rr_arbiter.sv ====
// round-robin arbiter
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter #(
   parameter int NUM_CLIENTS = 2
) (
   input  wire logic                   clk,
   input  wire logic                   i_arst_n,
   input  wire logic [NUM_CLIENTS-1:0] i_valid_candidate,
   output logic      [NUM_CLIENTS-1:0] o_winner_dec_id
);

   localparam int PTR_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

   logic [PTR_W-1:0] ptr;   // client with the highest priority this cycle
   logic [PTR_W-1:0] winner_idx;
   logic             any_grant;

   // walk the clients starting at the pointer, the first requester wins
   always_comb begin
      int   idx;
      logic found;
      o_winner_dec_id = '0;
      winner_idx      = '0;
      found           = 1'b0;
      for (int i = 0; i < NUM_CLIENTS; i++) begin
         idx = (int'(ptr) + i) % NUM_CLIENTS;
         if (!found && i_valid_candidate[idx]) begin
            found                = 1'b1;
            o_winner_dec_id[idx] = 1'b1;
            winner_idx           = PTR_W'(idx);
         end
      end
   end

   assign any_grant = |o_winner_dec_id;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ptr <= '0;   // client 0 first out of reset
      end else if (any_grant) begin
         // the winner drops to the lowest priority
         if (winner_idx == PTR_W'(NUM_CLIENTS - 1))
            ptr <= '0;
         else
            ptr <= winner_idx + PTR_W'(1);
      end
   end

endmodule

`default_nettype wire

// ==== mem_fifo.sv ====
// synchronous request FIFO
`timescale 1ns/10ps
`default_nettype none

module mem_fifo #(
   parameter int DATA_WIDTH = 8,
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                  clk,
   input  wire logic                  i_arst_n,
   input  wire logic                  i_push,
   input  wire logic [DATA_WIDTH-1:0] i_push_data,
   input  wire logic                  i_pop,
   output logic      [DATA_WIDTH-1:0] o_pop_data,
   output logic                       o_full,
   output logic                       o_empty
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic [CNT_W-1:0]      count_nxt;
   logic                  do_push;
   logic                  do_pop;

   assign do_push = i_push && !o_full;   // a push into a full buffer is ignored
   assign do_pop  = i_pop && !o_empty;

   always_comb begin
      count_nxt = count;
      if (do_push && !do_pop)
         count_nxt = count + CNT_W'(1);
      else if (do_pop && !do_push)
         count_nxt = count - CNT_W'(1);
   end

   // pointers wrap explicitly so a depth that is not a power of two works
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         o_full  <= 1'b0;
         o_empty <= 1'b1;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         count   <= count_nxt;
         o_full  <= (count_nxt == CNT_W'(FIFO_DEPTH));
         o_empty <= (count_nxt == '0);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= i_push_data;
   end

   assign o_pop_data = mem[rd_ptr];   // head is visible without a pop

endmodule

`default_nettype wire

// ==== mem_ss_param_pkg.sv ====
// memory subsystem shared types
`default_nettype none

package mem_ss_param_pkg;

   // byte address, wide enough for both 64KB regions
   localparam int ADDR_W = 20;
   localparam int CL_W   = 128;   // one cache line, 16 bytes
   localparam int TQ_W   = 2;     // transaction tag carried end to end

   typedef enum logic [0:0] {
      OP_RD = 1'b0,
      OP_WR = 1'b1
   } t_opcode;

   // request from a cache port, also the request toward the SRAM
   typedef struct packed {
      logic              valid;
      t_opcode           opcode;
      logic [ADDR_W-1:0] address;
      logic [TQ_W-1:0]   tq_id;
      logic [CL_W-1:0]   data;    // write line, ignored on reads
   } t_fm_req;

   // read response handed back to a cache
   typedef struct packed {
      logic            valid;
      logic [TQ_W-1:0] tq_id;
      logic [CL_W-1:0] data;
   } t_fm_rd_rsp;

   // read response from the SRAM, the address selects the owning port
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] address;
      logic [TQ_W-1:0]   tq_id;
      logic [CL_W-1:0]   data;
   } t_sram_rd_rsp;

   // instruction region, top address included
   localparam logic [ADDR_W-1:0] I_MEM_BASE = 20'h0_0000;
   localparam logic [ADDR_W-1:0] I_MEM_TOP  = 20'h0_FFFF;

   // data region sits right above it
   localparam logic [ADDR_W-1:0] D_MEM_BASE = 20'h1_0000;
   localparam logic [ADDR_W-1:0] D_MEM_TOP  = 20'h1_FFFF;

endpackage

`default_nettype wire
